//--- vsys_config.svh
/* Global widths, depths and CSR addresses of the vector system interconnect.
   Included by the package, the RTL modules and the testbench. */

`ifndef VSYS_CONFIG_SVH
`define VSYS_CONFIG_SVH

// bus and register widths
`define VSYS_ADDR_W     32
`define VSYS_XLEN       32
`define VSYS_MEM_W      64
`define VSYS_VREG_W     128   // vlenb derived from this

`define VSYS_SRC_DEPTH  32    // outstanding memory requests tracked

// vector CSR addresses
`define VSYS_CSR_VSTART 12'h008
`define VSYS_CSR_VXSAT  12'h009
`define VSYS_CSR_VXRM   12'h00A
`define VSYS_CSR_VCSR   12'h00F
`define VSYS_CSR_VL     12'hC20
`define VSYS_CSR_VTYPE  12'hC21
`define VSYS_CSR_VLENB  12'hC22

`endif

//--- vsys_pkg.sv
/* Request, response and CSR types shared by the interconnect and its testbench.
   Refer to them by scoped names. */

`default_nettype none

`include "vsys_config.svh"

package vsys_pkg;

    //////////////////////////////
    // memory side requests

    // scalar data request, one 32-bit lane
    typedef struct packed {
        logic                       valid;
        logic                       we;
        logic [`VSYS_ADDR_W-1:0]    addr;
        logic [`VSYS_XLEN/8-1:0]    be;
        logic [`VSYS_XLEN-1:0]      wdata;
    } xreq_t;

    // wide request, vector side and memory port
    typedef struct packed {
        logic                       valid;
        logic                       we;
        logic [`VSYS_ADDR_W-1:0]    addr;
        logic [`VSYS_MEM_W/8-1:0]   be;
        logic [`VSYS_MEM_W-1:0]     wdata;
    } wreq_t;

    // instruction fetch, read only
    typedef struct packed {
        logic                       valid;
        logic [`VSYS_ADDR_W-1:0]    addr;
    } ireq_t;

    typedef struct packed {
        logic                       rvalid;
        logic                       err;
        logic [`VSYS_XLEN-1:0]      rdata;
    } rsp_x_t;

    typedef struct packed {
        logic                       rvalid;
        logic                       err;
        logic [`VSYS_MEM_W-1:0]     rdata;
    } rsp_w_t;

    //////////////////////////////
    // CSR side

    typedef struct packed {
        logic [11:0]                addr;
        logic                       we;
        logic [`VSYS_XLEN-1:0]      wdata;
    } csr_req_t;

    // vcsr layout over a plain word
    typedef union packed {
        logic [`VSYS_XLEN-1:0]      raw;
        struct packed {
            logic [`VSYS_XLEN-4:0]  rsvd;
            logic [1:0]             vxrm;
            logic                   vxsat;
        } fields;
    } csr_word_u;

    typedef struct packed {
        logic                       pending_load;
        logic                       pending_store;
        logic [`VSYS_XLEN-1:0]      vl;
        logic [`VSYS_XLEN-1:0]      vtype;
    } vec_status_t;

endpackage

`default_nettype wire

//--- vcsr_file.sv
/* Vector CSR registers (vstart, vxsat, vxrm) with the scalar read and write decode.
   Reads are combinational, writes land on the next rising edge. */

`timescale 1ns/1ps
`default_nettype none

`include "vsys_config.svh"

module vcsr_file (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,
    input  wire vsys_pkg::csr_req_t     csr_i,
    output logic [`VSYS_XLEN-1:0]       csr_rdata_o,
    input  wire vsys_pkg::vec_status_t  status_i,
    output logic [`VSYS_XLEN-1:0]       vstart_o,
    output logic [1:0]                  vxrm_o,
    output logic                        vxsat_o
);

    localparam logic [`VSYS_XLEN-1:0] VLENB = `VSYS_VREG_W / 8;

    logic [`VSYS_XLEN-1:0] vstart_q;
    logic [1:0]            vxrm_q;
    logic                  vxsat_q;

    vsys_pkg::csr_word_u   wword;   // incoming write word
    vsys_pkg::csr_word_u   vcsr_rd;

    assign wword = csr_i.wdata;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vstart_q <= '0;
            vxrm_q   <= '0;
            vxsat_q  <= 1'b0;
        end else if (csr_i.we) begin
            case (csr_i.addr)
                `VSYS_CSR_VSTART: vstart_q <= wword.raw;
                `VSYS_CSR_VXSAT:  vxsat_q  <= wword.raw[0];
                `VSYS_CSR_VXRM:   vxrm_q   <= wword.raw[1:0];
                `VSYS_CSR_VCSR: begin   // alias of both fields
                    vxrm_q  <= wword.fields.vxrm;
                    vxsat_q <= wword.fields.vxsat;
                end
                default: ;  // vl, vtype, vlenb are read only
            endcase
        end
    end

    always_comb begin
        vcsr_rd.raw          = '0;
        vcsr_rd.fields.vxrm  = vxrm_q;
        vcsr_rd.fields.vxsat = vxsat_q;
    end

    always_comb begin
        case (csr_i.addr)
            `VSYS_CSR_VSTART: csr_rdata_o = vstart_q;
            `VSYS_CSR_VXSAT:  csr_rdata_o = {{(`VSYS_XLEN-1){1'b0}}, vxsat_q};
            `VSYS_CSR_VXRM:   csr_rdata_o = {{(`VSYS_XLEN-2){1'b0}}, vxrm_q};
            `VSYS_CSR_VCSR:   csr_rdata_o = vcsr_rd.raw;
            `VSYS_CSR_VL:     csr_rdata_o = status_i.vl;
            `VSYS_CSR_VTYPE:  csr_rdata_o = status_i.vtype;
            `VSYS_CSR_VLENB:  csr_rdata_o = VLENB;
            default:          csr_rdata_o = '0;
        endcase
    end

    assign vstart_o = vstart_q;
    assign vxrm_o   = vxrm_q;
    assign vxsat_o  = vxsat_q;

endmodule

`default_nettype wire

//--- data_arbiter.sv
/* Arbitrates scalar and vector data accesses onto the wide data path.
   Vector side has priority; scalar accesses are steered into their lane. */

`timescale 1ns/1ps
`default_nettype none

`include "vsys_config.svh"

module data_arbiter (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    // scalar core
    input  wire vsys_pkg::xreq_t        xreq_i,
    output logic                        xgnt_o,
    output vsys_pkg::rsp_x_t            xrsp_o,

    // vector unit
    input  wire vsys_pkg::wreq_t        vreq_i,
    output logic                        vgnt_o,
    output vsys_pkg::rsp_w_t            vrsp_o,
    input  wire vsys_pkg::vec_status_t  status_i,

    // wide data path towards memory arbiter
    output vsys_pkg::wreq_t             dreq_o,
    input  wire logic                   dgnt_i,
    input  wire vsys_pkg::rsp_w_t       drsp_i
);

    localparam int unsigned LANES    = `VSYS_MEM_W / `VSYS_XLEN;
    localparam int unsigned LANE_W   = $clog2(LANES);
    localparam int unsigned LANE_LSB = $clog2(`VSYS_XLEN / 8);
    localparam int unsigned XBE_W    = `VSYS_XLEN / 8;
    localparam int unsigned BE_W     = `VSYS_MEM_W / 8;

    logic              x_hold;
    logic              x_gnt;
    logic              v_gnt;
    logic              x_wait_q;
    logic              v_wait_q;
    logic [LANE_W-1:0] x_lane;
    logic [LANE_W-1:0] x_lane_q;  // lane of the outstanding scalar access

    assign x_lane = xreq_i.addr[LANE_LSB +: LANE_W];

    // a pending vector load only blocks scalar stores
    assign x_hold = vreq_i.valid
                  | status_i.pending_store
                  | (status_i.pending_load & xreq_i.we);

    //////////////////////////////
    // request path

    always_comb begin
        dreq_o.valid = vreq_i.valid | (xreq_i.valid & ~x_hold);
        dreq_o.we    = xreq_i.we;
        dreq_o.addr  = xreq_i.addr;
        dreq_o.be    = BE_W'(xreq_i.be) << (x_lane * XBE_W);
        dreq_o.wdata = {LANES{xreq_i.wdata}};   // same word in every lane
        if (vreq_i.valid) begin
            dreq_o = vreq_i;
        end
    end

    assign x_gnt  = dgnt_i & xreq_i.valid & ~x_hold;
    assign v_gnt  = dgnt_i & vreq_i.valid;
    assign xgnt_o = x_gnt;
    assign vgnt_o = v_gnt;

    //////////////////////////////
    // response tracking

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            x_wait_q <= 1'b0;
            v_wait_q <= 1'b0;
        end else begin
            if (x_gnt) begin
                x_wait_q <= 1'b1;
            end else if (drsp_i.rvalid) begin
                x_wait_q <= 1'b0;
            end
            if (v_gnt) begin
                v_wait_q <= ~vreq_i.we;     // stores get no response
            end else if (drsp_i.rvalid) begin
                v_wait_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (x_gnt) begin
            x_lane_q <= x_lane;
        end
    end

    always_comb begin
        xrsp_o.rvalid = x_wait_q & drsp_i.rvalid;
        xrsp_o.err    = drsp_i.err;
        xrsp_o.rdata  = drsp_i.rdata[x_lane_q * `VSYS_XLEN +: `VSYS_XLEN];
    end

    always_comb begin
        vrsp_o        = drsp_i;
        vrsp_o.rvalid = v_wait_q & drsp_i.rvalid;
    end

endmodule

`default_nettype wire

//--- mem_arbiter.sv
/* Shares the memory bus between instruction fetches and data accesses, data first.
   An in-order queue records each request's source to route the responses back. */

`timescale 1ns/1ps
`default_nettype none

`include "vsys_config.svh"

module mem_arbiter (
    input  wire logic               clk_i,
    input  wire logic               rst_ni,

    // instruction fetch
    input  wire vsys_pkg::ireq_t    ireq_i,
    output logic                    igrant_o,
    output vsys_pkg::rsp_x_t        irsp_o,

    // wide data path
    input  wire vsys_pkg::wreq_t    dreq_i,
    output logic                    dgnt_o,
    output vsys_pkg::rsp_w_t        drsp_o,

    // memory bus
    output vsys_pkg::wreq_t         mem_req_o,
    input  wire vsys_pkg::rsp_w_t   mem_rsp_i
);

    localparam int unsigned DEPTH    = `VSYS_SRC_DEPTH;
    localparam int unsigned CNT_W    = $clog2(DEPTH + 1);
    localparam int unsigned LANE_W   = $clog2(`VSYS_MEM_W / `VSYS_XLEN);
    localparam int unsigned LANE_LSB = $clog2(`VSYS_XLEN / 8);

    // one queue entry per outstanding request
    typedef struct packed {
        logic              data;    // 1 = data access, 0 = fetch
        logic [LANE_W-1:0] lane;    // fetch word within the bus
    } src_ent_t;

    src_ent_t [DEPTH-1:0] src_q, src_d;
    src_ent_t             src_new;
    logic [CNT_W-1:0]     cnt_q, cnt_d;
    logic                 push;

    //////////////////////////////
    // request side

    always_comb begin
        mem_req_o.valid = ireq_i.valid | dreq_i.valid;
        mem_req_o.we    = 1'b0;
        mem_req_o.addr  = ireq_i.addr;
        mem_req_o.be    = '1;
        mem_req_o.wdata = dreq_i.wdata;
        if (dreq_i.valid) begin
            mem_req_o.we   = dreq_i.we;
            mem_req_o.addr = dreq_i.addr;
            mem_req_o.be   = dreq_i.be;
        end
    end

    // memory takes every request at once
    assign dgnt_o   = dreq_i.valid;
    assign igrant_o = ireq_i.valid & ~dreq_i.valid;

    //////////////////////////////
    // source queue

    assign push         = igrant_o | dgnt_o;
    assign src_new.data = dgnt_o;
    assign src_new.lane = ireq_i.addr[LANE_LSB +: LANE_W];

    always_comb begin
        src_d = src_q;
        cnt_d = cnt_q;
        if (mem_rsp_i.rvalid) begin     // oldest entry leaves
            src_d = src_q >> $bits(src_ent_t);
            cnt_d = cnt_q - 1'b1;
        end
        if (push) begin
            src_d[cnt_d] = src_new;
            cnt_d        = cnt_d + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        src_q <= src_d;
    end

    //////////////////////////////
    // response routing

    always_comb begin
        irsp_o.rvalid = mem_rsp_i.rvalid & ~src_q[0].data;
        irsp_o.err    = mem_rsp_i.err;
        irsp_o.rdata  = mem_rsp_i.rdata[src_q[0].lane * `VSYS_XLEN +: `VSYS_XLEN];
    end

    always_comb begin
        drsp_o        = mem_rsp_i;
        drsp_o.rvalid = mem_rsp_i.rvalid & src_q[0].data;
    end

endmodule

`default_nettype wire

//--- vsys_interconnect.sv
/* Top level of the memory and CSR interconnect between the scalar core,
   the vector unit and the shared memory bus. */

`timescale 1ns/1ps
`default_nettype none

module vsys_interconnect (
    input  wire logic                   clk_i,
    input  wire logic                   rst_ni,

    // scalar data port
    input  wire vsys_pkg::xreq_t        xreq_i,
    output logic                        xgnt_o,
    output vsys_pkg::rsp_x_t            xrsp_o,

    // vector data port
    input  wire vsys_pkg::wreq_t        vreq_i,
    output logic                        vgnt_o,
    output vsys_pkg::rsp_w_t            vrsp_o,

    // fetch port
    input  wire vsys_pkg::ireq_t        ireq_i,
    output logic                        igrant_o,
    output vsys_pkg::rsp_x_t            irsp_o,

    // scalar CSR access and vector state
    input  wire vsys_pkg::csr_req_t     csr_i,
    output logic [31:0]                 csr_rdata_o,
    input  wire vsys_pkg::vec_status_t  status_i,
    output logic [31:0]                 vstart_o,
    output logic [1:0]                  vxrm_o,
    output logic                        vxsat_o,

    // memory bus
    output vsys_pkg::wreq_t             mem_req_o,
    input  wire vsys_pkg::rsp_w_t       mem_rsp_i
);

    vsys_pkg::wreq_t  dreq;     // merged data path
    logic             dgnt;
    vsys_pkg::rsp_w_t drsp;

    vcsr_file u_vcsr (
        .clk_i       ( clk_i       ),
        .rst_ni      ( rst_ni      ),
        .csr_i       ( csr_i       ),
        .csr_rdata_o ( csr_rdata_o ),
        .status_i    ( status_i    ),
        .vstart_o    ( vstart_o    ),
        .vxrm_o      ( vxrm_o      ),
        .vxsat_o     ( vxsat_o     )
    );

    data_arbiter u_data_arb (
        .clk_i    ( clk_i    ),
        .rst_ni   ( rst_ni   ),
        .xreq_i   ( xreq_i   ),
        .xgnt_o   ( xgnt_o   ),
        .xrsp_o   ( xrsp_o   ),
        .vreq_i   ( vreq_i   ),
        .vgnt_o   ( vgnt_o   ),
        .vrsp_o   ( vrsp_o   ),
        .status_i ( status_i ),
        .dreq_o   ( dreq     ),
        .dgnt_i   ( dgnt     ),
        .drsp_i   ( drsp     )
    );

    mem_arbiter u_mem_arb (
        .clk_i     ( clk_i     ),
        .rst_ni    ( rst_ni    ),
        .ireq_i    ( ireq_i    ),
        .igrant_o  ( igrant_o  ),
        .irsp_o    ( irsp_o    ),
        .dreq_i    ( dreq      ),
        .dgnt_o    ( dgnt      ),
        .drsp_o    ( drsp      ),
        .mem_req_o ( mem_req_o ),
        .mem_rsp_i ( mem_rsp_i )
    );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
/* Testbench memory for the interconnect's memory bus.
   Answers in order after 1 to 4 cycles; unwritten words read back their own address. */

`timescale 1ns/1ps
`default_nettype none

`include "vsys_config.svh"

module tb_mem_model (
    input  wire logic               clk_i,
    input  wire logic               rst_ni,
    input  wire vsys_pkg::wreq_t    req_i,
    output vsys_pkg::rsp_w_t        rsp_o
);

    logic [7:0]  mem [logic [31:0]];   // written bytes only
    logic [15:0] lfsr = 16'd25634;
    int unsigned cyc = 0;
    int unsigned last_due = 0;
    int unsigned due_q[$];
    logic [63:0] data_q[$];
    vsys_pkg::rsp_w_t rsp_q = '0;

    assign rsp_o = rsp_q;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // each 32-bit half holds its own byte address
    function automatic logic [7:0] byte_at(input logic [31:0] a);
        logic [31:0] half;
        half = a & ~32'h3;
        if (mem.exists(a))
            return mem[a];
        return half[8*a[1:0] +: 8];
    endfunction

    always @(posedge clk_i) begin
        logic [63:0] rd;
        logic [31:0] base;
        int unsigned lat;
        int unsigned due;
        if (!rst_ni) begin
            due_q.delete();
            data_q.delete();
        end else if (req_i.valid) begin
            base = {req_i.addr[31:3], 3'b000};
            for (int i = 0; i < 8; i++) begin
                if (req_i.we && req_i.be[i])
                    mem[base + i] = req_i.wdata[8*i +: 8];
                rd[8*i +: 8] = byte_at(base + i);
            end
            lat = 1;
            for (int b = 0; b < 2; b++) begin   // one step per bit
                lfsr = lfsr_next(lfsr);
                lat  = lat + (int'(lfsr[0]) << b);
            end
            due = (cyc + lat > last_due) ? cyc + lat : last_due + 1;
            last_due = due;
            due_q.push_back(due);
            data_q.push_back(rd);
        end
        cyc = cyc + 1;
    end

    always @(negedge clk_i) begin
        rsp_q <= '0;
        if (due_q.size() > 0 && due_q[0] <= cyc) begin
            rsp_q <= {1'b1, 1'b0, data_q[0]};
            void'(due_q.pop_front());
            void'(data_q.pop_front());
        end
    end

endmodule

`default_nettype wire

//--- tb_vsys.sv
/* Testbench top for the vector system interconnect.
   Walks a table of accesses through the DUT and checks grants, lanes and read data. */

`timescale 1ns/1ps
`default_nettype none

`include "vsys_config.svh"

module tb_vsys;

    localparam int NROWS = 23;
    localparam logic [2:0] K_X = 0, K_V = 1, K_BOTH = 2, K_FD = 3, K_CSR = 4;

    typedef struct packed {
        logic [2:0]  kind;
        logic        we;
        logic [31:0] addr;
        logic [7:0]  be;
        logic [63:0] wdata;
        logic        pl;
        logic        ps;
        logic        gnt;       // scalar grant expected
        logic [63:0] exp;       // read data, or memory be of a scalar store
        logic [31:0] faddr;     // fetch side of K_FD rows
        logic [31:0] fexp;
    } row_t;

    logic clk_i = 1'b0;
    logic rst_ni = 1'b0;
    vsys_pkg::xreq_t       xreq = '0;
    vsys_pkg::wreq_t       vreq = '0;
    vsys_pkg::ireq_t       ireq = '0;
    vsys_pkg::csr_req_t    csr = '0;
    vsys_pkg::vec_status_t status = '{1'b0, 1'b0, 32'h40, 32'hD1};
    vsys_pkg::rsp_x_t      xrsp, irsp;
    vsys_pkg::rsp_w_t      vrsp, mem_rsp;
    vsys_pkg::wreq_t       mem_req;
    logic        xgnt, vgnt, igrant, vxsat;
    logic [31:0] csr_rdata, vstart;
    logic [1:0]  vxrm;
    row_t        tbl [NROWS];

    vsys_interconnect DUT (
        .clk_i(clk_i), .rst_ni(rst_ni),
        .xreq_i(xreq), .xgnt_o(xgnt), .xrsp_o(xrsp),
        .vreq_i(vreq), .vgnt_o(vgnt), .vrsp_o(vrsp),
        .ireq_i(ireq), .igrant_o(igrant), .irsp_o(irsp),
        .csr_i(csr), .csr_rdata_o(csr_rdata), .status_i(status),
        .vstart_o(vstart), .vxrm_o(vxrm), .vxsat_o(vxsat),
        .mem_req_o(mem_req), .mem_rsp_i(mem_rsp)
    );

    tb_mem_model u_mem (.clk_i(clk_i), .rst_ni(rst_ni), .req_i(mem_req), .rsp_o(mem_rsp));

    always #5 clk_i = ~clk_i;

    initial begin
        #(NROWS * 200);
        $display("Timeout: the test table did not finish in time");
        $display("Something failed");
        $fatal(1);
    end

    task automatic give_up(input string msg);
        $display("%s at %0t", msg, $time);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("Fail at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] vcsr_word(input logic [1:0] rm, input logic sat);
        vsys_pkg::csr_word_u w;
        w.raw          = '0;
        w.fields.vxrm  = rm;
        w.fields.vxsat = sat;
        return w.raw;
    endfunction

    function automatic row_t make_row(input logic [2:0] kind, input logic we,
            input logic [31:0] addr, input logic [7:0] be, input logic [63:0] wdata,
            input logic pl, input logic ps, input logic gnt, input logic [63:0] exp,
            input logic [31:0] faddr, input logic [31:0] fexp);
        return '{kind, we, addr, be, wdata, pl, ps, gnt, exp, faddr, fexp};
    endfunction

    // all waits start at a falling edge, 1 ns after driving
    task automatic wait_x_gnt();
        int n;
        n = 0;
        #1;
        while (!xgnt) begin
            n++;
            if (n > 20)
                give_up("scalar request never granted");
            @(negedge clk_i);
            #1;
        end
    endtask

    task automatic wait_x_rsp(input logic do_check, input logic [31:0] exp);
        int n;
        n = 0;
        #1;
        while (!xrsp.rvalid) begin
            n++;
            if (n > 20)
                give_up("no scalar response");
            @(negedge clk_i);
            #1;
        end
        if (do_check)
            check("xrsp_o.rdata", 64'(xrsp.rdata), 64'(exp));
    endtask

    task automatic wait_v_rsp(input logic [63:0] exp);
        int n;
        n = 0;
        #1;
        while (!vrsp.rvalid) begin
            n++;
            if (n > 20)
                give_up("no vector response");
            @(negedge clk_i);
            #1;
        end
        check("vrsp_o.rdata", vrsp.rdata, exp);
    endtask

    task automatic collect_fd(input row_t r, inout logic got_x, inout logic got_i);
        if (xrsp.rvalid) begin
            check("xrsp_o.rdata", 64'(xrsp.rdata), r.exp);
            got_x = 1'b1;
        end
        if (irsp.rvalid) begin
            check("irsp_o.rdata", 64'(irsp.rdata), 64'(r.fexp));
            got_i = 1'b1;
        end
    endtask

    task automatic scalar_access(input row_t r);
        @(negedge clk_i);
        status.pending_load  = r.pl;
        status.pending_store = r.ps;
        xreq = '{1'b1, r.we, r.addr, r.be[3:0], r.wdata[31:0]};
        if (!r.gnt) begin
            repeat (3) begin
                #1;
                check("xgnt_o", 64'(xgnt), 64'(0));
                @(negedge clk_i);
            end
        end else begin
            wait_x_gnt();
            if (r.we) begin     // lane steering of a store
                check("mem_req_o.be", 64'(mem_req.be), r.exp);
                check("mem_req_o.wdata", mem_req.wdata, {2{r.wdata[31:0]}});
            end
            @(negedge clk_i);
        end
        xreq.valid = 1'b0;
        status.pending_load  = 1'b0;
        status.pending_store = 1'b0;
        if (r.gnt)
            wait_x_rsp(!r.we, r.exp[31:0]);
    endtask

    task automatic run_row(input row_t r);
        logic got_x;
        logic got_i;
        int   n;
        case (r.kind)
            K_X: scalar_access(r);
            K_V, K_BOTH: begin
                @(negedge clk_i);
                vreq = '{1'b1, r.we, r.addr, r.be, r.wdata};
                if (r.kind == K_BOTH) begin
                    xreq = '{1'b1, 1'b0, r.addr, 4'hF, 32'h0};
                    #1;
                    check("vgnt_o", 64'(vgnt), 64'(1));
                    check("xgnt_o", 64'(xgnt), 64'(0));
                    @(negedge clk_i);
                    xreq.valid = 1'b0;
                end else begin
                    #1;
                    check("vgnt_o", 64'(vgnt), 64'(1));
                    @(negedge clk_i);
                end
                vreq.valid = 1'b0;
                if (r.we) begin
                    repeat (6) begin
                        #1;
                        check("vrsp_o.rvalid", 64'(vrsp.rvalid), 64'(0));
                        @(negedge clk_i);
                    end
                end else begin
                    wait_v_rsp(r.exp);
                end
                if (r.kind == K_BOTH)
                    scalar_access(make_row(K_X, 1'b0, r.addr, 8'hF, '0, 1'b0, 1'b0, 1'b1,
                                           64'(r.exp[32*r.addr[2] +: 32]), '0, '0));
            end
            K_FD: begin
                got_x = 1'b0;
                got_i = 1'b0;
                @(negedge clk_i);
                xreq = '{1'b1, 1'b0, r.addr, 4'hF, 32'h0};
                ireq = '{1'b1, r.faddr};
                #1;
                check("xgnt_o", 64'(xgnt), 64'(1));
                check("igrant_o", 64'(igrant), 64'(0));   // data first
                @(negedge clk_i);
                xreq.valid = 1'b0;
                #1;
                check("igrant_o", 64'(igrant), 64'(1));
                collect_fd(r, got_x, got_i);
                @(negedge clk_i);
                ireq.valid = 1'b0;
                n = 0;
                while (!(got_x && got_i)) begin
                    #1;
                    collect_fd(r, got_x, got_i);
                    n++;
                    if (n > 20)
                        give_up("fetch or data response missing");
                    @(negedge clk_i);
                end
            end
            default: begin
                @(negedge clk_i);
                csr = '{r.addr[11:0], r.we, r.wdata[31:0]};
                #1;
                if (!r.we) begin
                    check("csr_rdata_o", 64'(csr_rdata), r.exp);
                    case (r.addr[11:0])     // register outputs follow the CSRs
                        `VSYS_CSR_VSTART: check("vstart_o", 64'(vstart), r.exp);
                        `VSYS_CSR_VXRM:   check("vxrm_o", 64'(vxrm), r.exp);
                        `VSYS_CSR_VXSAT:  check("vxsat_o", 64'(vxsat), r.exp);
                        `VSYS_CSR_VCSR: begin
                            check("vxrm_o", 64'(vxrm), 64'(r.exp[2:1]));
                            check("vxsat_o", 64'(vxsat), 64'(r.exp[0]));
                        end
                        default: ;
                    endcase
                end
                @(negedge clk_i);
                csr.we = 1'b0;
            end
        endcase
    endtask

    initial begin
        tbl[0]  = make_row(K_X, 1, 32'h104, 8'h3, 64'hAABBCCDD, 0, 0, 1, 64'h30, 0, 0);
        tbl[1]  = make_row(K_X, 0, 32'h104, 8'hF, 0, 0, 0, 1, 64'h0000CCDD, 0, 0);
        tbl[2]  = make_row(K_X, 0, 32'h100, 8'hF, 0, 0, 0, 1, 64'h100, 0, 0);
        tbl[3]  = make_row(K_BOTH, 0, 32'h104, 8'hFF, 0, 0, 0, 1,
                           64'h0000CCDD_00000100, 0, 0);
        tbl[4]  = make_row(K_V, 1, 32'h108, 8'hFF, 64'h11223344_55667788, 0, 0, 1, 0, 0, 0);
        tbl[5]  = make_row(K_V, 0, 32'h108, 8'hFF, 0, 0, 0, 1, 64'h11223344_55667788, 0, 0);
        tbl[6]  = make_row(K_X, 0, 32'h108, 8'hF, 0, 0, 1, 0, 0, 0, 0);
        tbl[7]  = make_row(K_X, 0, 32'h10C, 8'hF, 0, 1, 0, 1, 64'h11223344, 0, 0);
        tbl[8]  = make_row(K_X, 1, 32'h108, 8'hF, 64'hDEAD, 1, 0, 0, 0, 0, 0);
        tbl[9]  = make_row(K_FD, 0, 32'h100, 8'hF, 0, 0, 0, 1, 64'h100, 32'h204, 32'h204);
        tbl[10] = make_row(K_FD, 0, 32'h10C, 8'hF, 0, 0, 0, 1, 64'h11223344,
                           32'h300, 32'h300);
        tbl[11] = make_row(K_CSR, 1, `VSYS_CSR_VCSR, 0, 64'(vcsr_word(2, 1)), 0, 0, 0, 0, 0, 0);
        tbl[12] = make_row(K_CSR, 0, `VSYS_CSR_VXRM, 0, 0, 0, 0, 0, 64'd2, 0, 0);
        tbl[13] = make_row(K_CSR, 0, `VSYS_CSR_VXSAT, 0, 0, 0, 0, 0, 64'd1, 0, 0);
        tbl[14] = make_row(K_CSR, 1, `VSYS_CSR_VXSAT, 0, 0, 0, 0, 0, 0, 0, 0);
        tbl[15] = make_row(K_CSR, 0, `VSYS_CSR_VCSR, 0, 0, 0, 0, 0, 64'(vcsr_word(2, 0)), 0, 0);
        tbl[16] = make_row(K_CSR, 0, `VSYS_CSR_VXRM, 0, 0, 0, 0, 0, 64'd2, 0, 0);
        tbl[17] = make_row(K_CSR, 0, `VSYS_CSR_VL, 0, 0, 0, 0, 0, 64'h40, 0, 0);
        tbl[18] = make_row(K_CSR, 0, `VSYS_CSR_VTYPE, 0, 0, 0, 0, 0, 64'hD1, 0, 0);
        tbl[19] = make_row(K_CSR, 0, `VSYS_CSR_VLENB, 0, 0, 0, 0, 0, 64'd16, 0, 0);
        tbl[20] = make_row(K_CSR, 0, `VSYS_CSR_VSTART, 0, 0, 0, 0, 0, 64'd0, 0, 0);
        tbl[21] = make_row(K_CSR, 1, `VSYS_CSR_VSTART, 0, 64'h25, 0, 0, 0, 0, 0, 0);
        tbl[22] = make_row(K_CSR, 0, `VSYS_CSR_VSTART, 0, 0, 0, 0, 0, 64'h25, 0, 0);

        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        for (int i = 0; i < NROWS; i++)
            run_row(tbl[i]);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+.
vsys_pkg.sv
vcsr_file.sv
data_arbiter.sv
mem_arbiter.sv
vsys_interconnect.sv
tb_mem_model.sv
tb_vsys.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the interconnect testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_vsys -f list.f -o vsys_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/vsys_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
